// File: rtl/dc_cfg.svh
// Data memory subsystem configuration
`ifndef DC_CFG_SVH
`define DC_CFG_SVH

// Byte address width
`define DC_ADDR_W 16

// Data word width in bits
`define DC_DATA_W 64

// Number of words in the data memory
`define DC_MEM_WORDS 256

// Transaction id width, the all-ones id marks an AMO
`define DC_TID_W 4

// Extra cycles an AMO keeps the memory busy
`define DC_AMO_LAT 1

`endif

// File: rtl/dc_pkg.sv
// Data memory subsystem types
`include "dc_cfg.svh"

package dc_pkg;

  typedef logic [`DC_ADDR_W-1:0]   addr_t;
  typedef logic [`DC_DATA_W-1:0]   data_t;
  typedef logic [`DC_DATA_W/8-1:0] be_t;
  typedef logic [`DC_TID_W-1:0]    tid_t;
  typedef logic [1:0]              size_t;

  // Port source id
  typedef logic sid_t;

  localparam sid_t  SID_LOAD  = 1'b0;
  localparam sid_t  SID_STORE = 1'b1;
  localparam tid_t  AMO_TID   = '1;
  localparam size_t SIZE_WORD = 2'b10;

  // AMO opcode as issued by the core
  typedef enum logic [3:0] {
    AMO_NONE,
    AMO_LR,
    AMO_SC,
    AMO_SWAP,
    AMO_ADD,
    AMO_AND,
    AMO_OR,
    AMO_XOR,
    AMO_MAX,
    AMO_MAXU,
    AMO_MIN,
    AMO_MINU
  } amo_op_e;

  // Operation seen by the data memory
  typedef enum logic [3:0] {
    MEM_LOAD,
    MEM_STORE,
    MEM_AMO_SWAP,
    MEM_AMO_ADD,
    MEM_AMO_AND,
    MEM_AMO_OR,
    MEM_AMO_XOR,
    MEM_AMO_MAX,
    MEM_AMO_MAXU,
    MEM_AMO_MIN,
    MEM_AMO_MINU
  } mem_op_e;

  typedef struct packed {
    logic  data_req;
    addr_t addr;
    be_t   data_be;
    size_t data_size;
    tid_t  data_id;
  } load_req_t;

  typedef struct packed {
    logic  data_gnt;
    logic  data_rvalid;
    tid_t  data_rid;
    data_t data_rdata;
  } load_rsp_t;

  typedef struct packed {
    logic  data_req;
    addr_t addr;
    data_t data_wdata;
    be_t   data_be;
    size_t data_size;
  } store_req_t;

  typedef struct packed {
    logic data_gnt;
  } store_rsp_t;

  typedef struct packed {
    logic    req;
    amo_op_e amo_op;
    size_t   size;
    addr_t   operand_a;
    data_t   operand_b;
  } amo_req_t;

  typedef struct packed {
    logic  ack;
    data_t result;
  } amo_rsp_t;

  typedef struct packed {
    addr_t   addr;
    data_t   wdata;
    mem_op_e op;
    be_t     be;
    size_t   size;
    sid_t    sid;
    tid_t    tid;
    logic    need_rsp;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    sid_t  sid;
    tid_t  tid;
  } mem_rsp_t;

endpackage

// File: rtl/core_port_adapter.sv
// Core data port adapter
`timescale 1ns/10ps
`include "dc_cfg.svh"

module core_port_adapter
  import dc_pkg::*;
#(
  parameter bit  IS_LOAD_PORT = 1'b1,
  parameter type core_req_t   = load_req_t,
  parameter type core_rsp_t   = load_rsp_t
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  input  amo_req_t  amo_req_i,
  output amo_rsp_t  amo_rsp_o,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  output mem_req_t  mem_req_o,
  input  logic      mem_rsp_valid_i,
  input  mem_rsp_t  mem_rsp_i
);

  if (IS_LOAD_PORT) begin : g_load
    // Loads always want data back, core id travels as tid
    always_comb begin
      mem_req_o          = '0;
      mem_req_o.addr     = core_req_i.addr;
      mem_req_o.op       = MEM_LOAD;
      mem_req_o.be       = core_req_i.data_be;
      mem_req_o.size     = core_req_i.data_size;
      mem_req_o.sid      = SID_LOAD;
      mem_req_o.tid      = core_req_i.data_id;
      mem_req_o.need_rsp = 1'b1;
    end

    assign mem_req_valid_o = core_req_i.data_req;

    always_comb begin
      core_rsp_o.data_gnt    = mem_req_ready_i;
      core_rsp_o.data_rvalid = mem_rsp_valid_i;
      core_rsp_o.data_rid    = mem_rsp_i.tid;
      core_rsp_o.data_rdata  = mem_rsp_i.rdata;
    end

    assign amo_rsp_o = '0;
  end else begin : g_store
    logic        forward_store;
    logic        forward_amo;
    logic        amo_is_word;
    logic        amo_is_hi;
    data_t       amo_wdata;
    be_t         amo_be;
    mem_op_e     amo_op;
    logic        rsp_is_word_q;
    logic        rsp_is_hi_q;
    logic [31:0] rsp_half;

    assign forward_store = core_req_i.data_req;
    assign forward_amo   = amo_req_i.req;

    always_comb begin
      amo_is_word = (amo_req_i.size == SIZE_WORD);
      amo_is_hi   = amo_req_i.operand_a[2];
      // Word operand copied into both halves, byte enables pick the half
      amo_wdata = amo_is_word ? {2{amo_req_i.operand_b[31:0]}} : amo_req_i.operand_b;
      if (!amo_is_word) begin
        amo_be = '1;
      end else if (amo_is_hi) begin
        amo_be = 8'hf0;
      end else begin
        amo_be = 8'h0f;
      end

      // LR and SC fall back to a plain read
      case (amo_req_i.amo_op)
        AMO_SWAP: amo_op = MEM_AMO_SWAP;
        AMO_ADD:  amo_op = MEM_AMO_ADD;
        AMO_AND:  amo_op = MEM_AMO_AND;
        AMO_OR:   amo_op = MEM_AMO_OR;
        AMO_XOR:  amo_op = MEM_AMO_XOR;
        AMO_MAX:  amo_op = MEM_AMO_MAX;
        AMO_MAXU: amo_op = MEM_AMO_MAXU;
        AMO_MIN:  amo_op = MEM_AMO_MIN;
        AMO_MINU: amo_op = MEM_AMO_MINU;
        default:  amo_op = MEM_LOAD;
      endcase
    end

    always_comb begin
      mem_req_o.addr     = forward_amo ? amo_req_i.operand_a : core_req_i.addr;
      mem_req_o.wdata    = forward_amo ? amo_wdata : core_req_i.data_wdata;
      mem_req_o.op       = forward_amo ? amo_op : MEM_STORE;
      mem_req_o.be       = forward_amo ? amo_be : core_req_i.data_be;
      mem_req_o.size     = forward_amo ? amo_req_i.size : core_req_i.data_size;
      mem_req_o.sid      = SID_STORE;
      mem_req_o.tid      = forward_amo ? AMO_TID : '0;
      mem_req_o.need_rsp = forward_amo;
    end

    assign mem_req_valid_o = forward_store | forward_amo;

    // Half select kept until the AMO result comes back
    always_ff @(posedge clk_i) begin
      if (mem_req_valid_o && mem_req_ready_i && forward_amo) begin
        rsp_is_word_q <= amo_is_word;
        rsp_is_hi_q   <= amo_is_hi;
      end
    end

    assign rsp_half = rsp_is_hi_q ? mem_rsp_i.rdata[63:32] : mem_rsp_i.rdata[31:0];

    always_comb begin
      core_rsp_o.data_gnt = mem_req_ready_i;
      amo_rsp_o.ack       = mem_rsp_valid_i && (mem_rsp_i.tid == AMO_TID);
      amo_rsp_o.result    = rsp_is_word_q ? {{32{rsp_half[31]}}, rsp_half}
                                          : mem_rsp_i.rdata;
    end
  end

endmodule

// File: rtl/port_arbiter.sv
// Two-port round-robin request arbiter
`timescale 1ns/10ps

module port_arbiter
  import dc_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic     [1:0] in_valid_i,
  output logic     [1:0] in_ready_o,
  input  mem_req_t [1:0] in_req_i,
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output mem_req_t       out_req_o,
  input  logic           rsp_valid_i,
  input  mem_rsp_t       rsp_i,
  output logic     [1:0] rsp_valid_o
);

  sid_t last_q;
  sid_t pick;
  logic both;

  assign both = &in_valid_i;

  // On contention the port that lost last time goes first
  assign pick = both ? ~last_q : sid_t'(in_valid_i[1]);

  assign out_valid_o = |in_valid_i;

  always_comb begin
    out_req_o     = in_req_i[pick];
    out_req_o.sid = pick;
  end

  // A port is held off only while the other one wins
  assign in_ready_o[SID_LOAD]  = out_ready_i && !(both && (pick != SID_LOAD));
  assign in_ready_o[SID_STORE] = out_ready_i && !(both && (pick != SID_STORE));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= SID_STORE;
    end else if (out_valid_o && out_ready_i) begin
      last_q <= pick;
    end
  end

  // Responses steered back by source id
  assign rsp_valid_o[SID_LOAD]  = rsp_valid_i && (rsp_i.sid == SID_LOAD);
  assign rsp_valid_o[SID_STORE] = rsp_valid_i && (rsp_i.sid == SID_STORE);

endmodule

// File: rtl/amo_data_mem.sv
// Data memory with AMO support
`timescale 1ns/10ps
`include "dc_cfg.svh"

module amo_data_mem
  import dc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o
);

  localparam int OFF_W = $clog2(`DC_DATA_W / 8);
  localparam int IDX_W = $clog2(`DC_MEM_WORDS);

  data_t            mem_q [`DC_MEM_WORDS];
  logic             accept;
  logic [IDX_W-1:0] req_idx;
  logic             s1_valid_q;
  mem_req_t         s1_req_q;
  logic [IDX_W-1:0] s1_idx;
  logic             s1_is_amo;
  logic             s1_is_word;
  logic [31:0]      old_half;
  data_t            old_word;
  data_t            op_a;
  data_t            op_b;
  data_t            amo_res;
  data_t            amo_word;
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  data_t            wr_data;
  be_t              wr_be;

  function automatic data_t amo_compute(mem_op_e op, data_t a, data_t b);
    logic  lt_s;
    logic  lt_u;
    data_t res;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (op)
      MEM_AMO_SWAP: res = b;
      MEM_AMO_ADD:  res = a + b;
      MEM_AMO_AND:  res = a & b;
      MEM_AMO_OR:   res = a | b;
      MEM_AMO_XOR:  res = a ^ b;
      MEM_AMO_MAX:  res = lt_s ? b : a;
      MEM_AMO_MAXU: res = lt_u ? b : a;
      MEM_AMO_MIN:  res = lt_s ? a : b;
      MEM_AMO_MINU: res = lt_u ? a : b;
      default:      res = a;
    endcase
    return res;
  endfunction

  assign req_idx = req_i.addr[OFF_W +: IDX_W];
  assign s1_idx  = s1_req_q.addr[OFF_W +: IDX_W];

  // An AMO in its second cycle blocks new requests
  assign s1_is_amo   = s1_valid_q && (s1_req_q.op != MEM_LOAD) && (s1_req_q.op != MEM_STORE);
  assign req_ready_o = !s1_is_amo;
  assign accept      = req_valid_i && req_ready_o;

  assign old_word = mem_q[s1_idx];

  always_comb begin
    s1_is_word = (s1_req_q.size == SIZE_WORD);
    old_half   = s1_req_q.be[4] ? old_word[63:32] : old_word[31:0];
    // Word ops run sign-extended, which keeps both signed and unsigned order
    op_a     = s1_is_word ? {{32{old_half[31]}}, old_half} : old_word;
    op_b     = s1_is_word ? {{32{s1_req_q.wdata[31]}}, s1_req_q.wdata[31:0]}
                          : s1_req_q.wdata;
    amo_res  = amo_compute(s1_req_q.op, op_a, op_b);
    amo_word = s1_is_word ? {2{amo_res[31:0]}} : amo_res;
  end

  // Single write port, AMO write-back and new stores never meet
  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = req_idx;
    wr_data = req_i.wdata;
    wr_be   = req_i.be;
    if (s1_is_amo) begin
      wr_en   = 1'b1;
      wr_idx  = s1_idx;
      wr_data = amo_word;
      wr_be   = s1_req_q.be;
    end else if (accept && (req_i.op == MEM_STORE)) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `DC_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < `DC_DATA_W / 8; b++) begin
        if (wr_be[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= accept && (req_i.op != MEM_STORE);
      rsp_valid_o <= s1_valid_q && s1_req_q.need_rsp;
    end
  end

  // Old word goes back for loads and AMOs alike
  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_req_q <= req_i;
    end
    if (s1_valid_q) begin
      rsp_o.rdata <= old_word;
      rsp_o.sid   <= s1_req_q.sid;
      rsp_o.tid   <= s1_req_q.tid;
    end
  end

endmodule

// File: rtl/dmem_subsys_top.sv
// Data memory subsystem top level
`timescale 1ns/10ps

module dmem_subsys_top
  import dc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  load_req_t  load_req_i,
  output load_rsp_t  load_rsp_o,
  input  store_req_t store_req_i,
  output store_rsp_t store_rsp_o,
  input  amo_req_t   amo_req_i,
  output amo_rsp_t   amo_rsp_o
);

  logic     [1:0] adp_valid;
  logic     [1:0] adp_ready;
  mem_req_t [1:0] adp_req;
  logic     [1:0] port_rsp_valid;
  logic           mem_valid;
  logic           mem_ready;
  mem_req_t       mem_req;
  logic           mem_rsp_valid;
  mem_rsp_t       mem_rsp;

  core_port_adapter #(
    .IS_LOAD_PORT (1'b1),
    .core_req_t   (load_req_t),
    .core_rsp_t   (load_rsp_t)
  ) u_load_adapter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .core_req_i      (load_req_i),
    .core_rsp_o      (load_rsp_o),
    .amo_req_i       ('0),
    .amo_rsp_o       (),
    .mem_req_valid_o (adp_valid[SID_LOAD]),
    .mem_req_ready_i (adp_ready[SID_LOAD]),
    .mem_req_o       (adp_req[SID_LOAD]),
    .mem_rsp_valid_i (port_rsp_valid[SID_LOAD]),
    .mem_rsp_i       (mem_rsp)
  );

  core_port_adapter #(
    .IS_LOAD_PORT (1'b0),
    .core_req_t   (store_req_t),
    .core_rsp_t   (store_rsp_t)
  ) u_store_adapter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .core_req_i      (store_req_i),
    .core_rsp_o      (store_rsp_o),
    .amo_req_i       (amo_req_i),
    .amo_rsp_o       (amo_rsp_o),
    .mem_req_valid_o (adp_valid[SID_STORE]),
    .mem_req_ready_i (adp_ready[SID_STORE]),
    .mem_req_o       (adp_req[SID_STORE]),
    .mem_rsp_valid_i (port_rsp_valid[SID_STORE]),
    .mem_rsp_i       (mem_rsp)
  );

  port_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (adp_valid),
    .in_ready_o  (adp_ready),
    .in_req_i    (adp_req),
    .out_valid_o (mem_valid),
    .out_ready_i (mem_ready),
    .out_req_o   (mem_req),
    .rsp_valid_i (mem_rsp_valid),
    .rsp_i       (mem_rsp),
    .rsp_valid_o (port_rsp_valid)
  );

  amo_data_mem u_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (mem_valid),
    .req_ready_o (mem_ready),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_o       (mem_rsp)
  );

endmodule

// File: verif/dmem_assert.sv
// Data memory protocol assertions
`timescale 1ns/10ps

module dmem_assert (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_a_i,
  input logic       req_b_i,
  input logic [1:0] valid_i,
  input logic [1:0] ready_i,
  input logic       amo_fire_i,
  input logic       amo_ack_i
);

  int fail_count = 0;

  // Store and AMO share the store port
  a_req_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(req_a_i && req_b_i))
    else begin
      $error("store and AMO requests raised together");
      fail_count++;
    end

  a_hold_0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i[0] && !ready_i[0] |=> valid_i[0])
    else begin
      $error("valid on input 0 dropped before ready");
      fail_count++;
    end

  a_hold_1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i[1] && !ready_i[1] |=> valid_i[1])
    else begin
      $error("valid on input 1 dropped before ready");
      fail_count++;
    end

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(valid_i & ready_i))
    else begin
      $error("more than one input granted");
      fail_count++;
    end

  // Old value comes back two edges after acceptance
  a_amo_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    amo_fire_i |-> ##2 amo_ack_i)
    else begin
      $error("accepted AMO not acknowledged");
      fail_count++;
    end

endmodule

bind core_port_adapter dmem_assert u_dmem_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_a_i    (core_req_i.data_req),
  .req_b_i    (amo_req_i.req),
  .valid_i    ({1'b0, mem_req_valid_o}),
  .ready_i    ({1'b0, mem_req_ready_i}),
  .amo_fire_i (mem_req_valid_o && mem_req_ready_i && amo_req_i.req),
  .amo_ack_i  (amo_rsp_o.ack)
);

bind port_arbiter dmem_assert u_dmem_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_a_i    (1'b0),
  .req_b_i    (1'b0),
  .valid_i    (in_valid_i),
  .ready_i    (in_ready_o),
  .amo_fire_i (1'b0),
  .amo_ack_i  (1'b0)
);

// File: verif/tb_top.sv
// Data memory subsystem testbench
`timescale 1ns/10ps
`include "dc_cfg.svh"

module tb_top
  import dc_pkg::*;
();

  localparam int N_STLD = 32;
  localparam int REP64  = 3;
  localparam int REP32  = 2;
  localparam int N_CONC = 120;
  localparam int N_DUMP = 32;
  // Loads and store-port operations over all tests
  localparam int TOTAL_TXN = 2 * N_STLD + 2 * 9 * REP64 + 2 * 9 * 2 * REP32
                           + 2 * N_CONC + N_DUMP;

  // One queued operation for the store port
  typedef struct packed {
    logic       is_amo;
    store_req_t st;
    amo_req_t   amo;
  } st_op_t;

  typedef struct packed {
    tid_t  id;
    data_t data;
  } ld_exp_t;

  logic       clk;
  logic       rst_n;
  load_req_t  load_req  = '0;
  load_rsp_t  load_rsp;
  store_req_t store_req = '0;
  store_rsp_t store_rsp;
  amo_req_t   amo_req   = '0;
  amo_rsp_t   amo_rsp;

  int        seed         = 84200;
  int        err_count    = 0;
  int        check_count  = 0;
  int        tests_failed = 0;
  logic      ld_fire      = 1'b0;
  logic      st_fire      = 1'b0;
  data_t     model_mem [`DC_MEM_WORDS] = '{default: '0};
  load_req_t ld_q [$];
  st_op_t    st_q [$];
  ld_exp_t   exp_ld_q [$];
  data_t     exp_amo_q [$];
  amo_op_e   amo_ops [9] = '{AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR, AMO_XOR,
                             AMO_MAX, AMO_MAXU, AMO_MIN, AMO_MINU};

  dmem_subsys_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .load_req_i  (load_req),
    .load_rsp_o  (load_rsp),
    .store_req_i (store_req),
    .store_rsp_o (store_rsp),
    .amo_req_i   (amo_req),
    .amo_rsp_o   (amo_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return {8'h00, r[4:0], 3'b000};
  endfunction

  function automatic data_t rand_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic amo_op_e rand_op();
    logic [31:0] r;
    logic [3:0]  k;
    r = $random(seed);
    k = 4'(r % 32'd9);
    return amo_ops[k];
  endfunction

  // RISC-V AMO rule, word ops look only at the low 32 bits
  function automatic data_t amo_apply(amo_op_e op, logic is_word, data_t a, data_t b);
    logic  lt_s;
    logic  lt_u;
    data_t r;
    if (is_word) begin
      lt_s = $signed(a[31:0]) < $signed(b[31:0]);
      lt_u = a[31:0] < b[31:0];
    end else begin
      lt_s = $signed(a) < $signed(b);
      lt_u = a < b;
    end
    case (op)
      AMO_SWAP: r = b;
      AMO_ADD:  r = a + b;
      AMO_AND:  r = a & b;
      AMO_OR:   r = a | b;
      AMO_XOR:  r = a ^ b;
      AMO_MAX:  r = lt_s ? b : a;
      AMO_MAXU: r = lt_u ? b : a;
      AMO_MIN:  r = lt_s ? a : b;
      default:  r = lt_u ? a : b;
    endcase
    return r;
  endfunction

  task automatic push_load(addr_t addr);
    logic [31:0] r;
    load_req_t   l;
    r           = $random(seed);
    l           = '0;
    l.data_req  = 1'b1;
    l.addr      = addr;
    l.data_be   = '1;
    l.data_size = 2'b11;
    l.data_id   = r[3:0];
    ld_q.push_back(l);
  endtask

  task automatic push_store(addr_t addr, data_t data, be_t be);
    st_op_t o;
    o              = '0;
    o.st.data_req  = 1'b1;
    o.st.addr      = addr;
    o.st.data_wdata = data;
    o.st.data_be   = be;
    o.st.data_size = 2'b11;
    st_q.push_back(o);
  endtask

  task automatic push_amo(amo_op_e op, logic is_word, addr_t addr, data_t opnd);
    st_op_t o;
    o               = '0;
    o.is_amo        = 1'b1;
    o.amo.req       = 1'b1;
    o.amo.amo_op    = op;
    o.amo.size      = is_word ? SIZE_WORD : 2'b11;
    o.amo.operand_a = addr;
    o.amo.operand_b = opnd;
    st_q.push_back(o);
  endtask

  task automatic model_store(store_req_t s);
    for (int b = 0; b < 8; b++) begin
      if (s.data_be[b]) begin
        model_mem[s.addr[3 +: 8]][8*b +: 8] = s.data_wdata[8*b +: 8];
      end
    end
  endtask

  task automatic model_amo(amo_req_t a);
    logic [7:0]  idx;
    data_t       old;
    logic [31:0] half;
    data_t       nv;
    idx = a.operand_a[3 +: 8];
    old = model_mem[idx];
    if (a.size == SIZE_WORD) begin
      half = a.operand_a[2] ? old[63:32] : old[31:0];
      nv   = amo_apply(a.amo_op, 1'b1, {32'h0, half}, a.operand_b);
      if (a.operand_a[2]) begin
        model_mem[idx][63:32] = nv[31:0];
      end else begin
        model_mem[idx][31:0] = nv[31:0];
      end
      exp_amo_q.push_back({{32{half[31]}}, half});
    end else begin
      model_mem[idx] = amo_apply(a.amo_op, 1'b0, old, a.operand_b);
      exp_amo_q.push_back(old);
    end
  endtask

  task automatic check_responses();
    ld_exp_t le;
    data_t   ae;
    if (load_rsp.data_rvalid) begin
      if (exp_ld_q.size() == 0) begin
        $display("Load response at %0t without an outstanding load", $time);
        err_count++;
      end else begin
        le = exp_ld_q.pop_front();
        check_count++;
        if (load_rsp.data_rid !== le.id) begin
          $display("Mismatch data_rid: expected %h, actual %h", le.id, load_rsp.data_rid);
          err_count++;
        end
        if (load_rsp.data_rdata !== le.data) begin
          $display("Mismatch data_rdata: expected %h, actual %h", le.data,
                   load_rsp.data_rdata);
          err_count++;
        end
      end
    end
    if (amo_rsp.ack) begin
      if (exp_amo_q.size() == 0) begin
        $display("AMO ack at %0t without an outstanding AMO", $time);
        err_count++;
      end else begin
        ae = exp_amo_q.pop_front();
        check_count++;
        if (amo_rsp.result !== ae) begin
          $display("Mismatch amo result: expected %h, actual %h", ae, amo_rsp.result);
          err_count++;
        end
      end
    end
  endtask

  // Model follows the grants in the order they happen
  always @(posedge clk) begin : monitor
    ld_exp_t e;
    if (!rst_n) begin
      ld_fire = 1'b0;
      st_fire = 1'b0;
    end else begin
      check_responses();
      ld_fire = load_req.data_req && load_rsp.data_gnt;
      st_fire = (store_req.data_req || amo_req.req) && store_rsp.data_gnt;
      if (ld_fire && st_fire) begin
        $display("Both ports granted in the same cycle at %0t", $time);
        err_count++;
      end
      if (ld_fire) begin
        e.id   = load_req.data_id;
        e.data = model_mem[load_req.addr[3 +: 8]];
        exp_ld_q.push_back(e);
      end
      if (st_fire && amo_req.req) begin
        model_amo(amo_req);
      end else if (st_fire) begin
        model_store(store_req);
      end
    end
  end

  // Requests hold until granted, the next one follows right away
  always @(negedge clk) begin : driver
    st_op_t op;
    if (!rst_n) begin
      load_req  = '0;
      store_req = '0;
      amo_req   = '0;
    end else begin
      if (!load_req.data_req || ld_fire) begin
        if (ld_q.size() > 0) begin
          load_req = ld_q.pop_front();
        end else begin
          load_req = '0;
        end
      end
      if (!(store_req.data_req || amo_req.req) || st_fire) begin
        op        = (st_q.size() > 0) ? st_q.pop_front() : '0;
        store_req = op.is_amo ? '0 : op.st;
        amo_req   = op.is_amo ? op.amo : '0;
      end
    end
  end

  task automatic wait_idle();
    @(negedge clk);
    while (ld_q.size() != 0 || st_q.size() != 0 || load_req.data_req ||
           store_req.data_req || amo_req.req || exp_ld_q.size() != 0 ||
           exp_amo_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(string name, int err_before);
    if (err_count == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_count - err_before);
      tests_failed++;
    end
  endtask

  initial begin : watchdog
    repeat (20 * TOTAL_TXN) @(posedge clk);
    $display("Timeout after %0d cycles, transactions still outstanding", 20 * TOTAL_TXN);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    addr_t       addr_list [N_STLD];
    addr_t       a;
    logic [31:0] r;
    int          err_before;
    int          assert_fails;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err_before = err_count;
    if (load_rsp.data_rvalid !== 1'b0) begin
      $display("Mismatch data_rvalid: expected %h, actual %h", 1'b0, load_rsp.data_rvalid);
      err_count++;
    end
    if (amo_rsp.ack !== 1'b0) begin
      $display("Mismatch amo ack: expected %h, actual %h", 1'b0, amo_rsp.ack);
      err_count++;
    end
    if (load_rsp.data_gnt !== 1'b1) begin
      $display("Mismatch load data_gnt: expected %h, actual %h", 1'b1, load_rsp.data_gnt);
      err_count++;
    end
    if (store_rsp.data_gnt !== 1'b1) begin
      $display("Mismatch store data_gnt: expected %h, actual %h", 1'b1, store_rsp.data_gnt);
      err_count++;
    end
    report_test("reset_state", err_before);

    err_before = err_count;
    for (int i = 0; i < N_STLD; i++) begin
      addr_list[i] = rand_addr();
      r = $random(seed);
      push_store(addr_list[i], rand_data(), r[7:0]);
    end
    wait_idle();
    for (int i = 0; i < N_STLD; i++) begin
      push_load(addr_list[i]);
    end
    wait_idle();
    report_test("store_load", err_before);

    err_before = err_count;
    foreach (amo_ops[k]) begin
      for (int rep = 0; rep < REP64; rep++) begin
        a = rand_addr();
        push_amo(amo_ops[k], 1'b0, a, rand_data());
        wait_idle();
        push_load(a);
        wait_idle();
      end
    end
    report_test("amo_double", err_before);

    err_before = err_count;
    foreach (amo_ops[k]) begin
      for (int h = 0; h < 2; h++) begin
        for (int rep = 0; rep < REP32; rep++) begin
          a    = rand_addr();
          a[2] = h[0];
          push_amo(amo_ops[k], 1'b1, a, rand_data());
          wait_idle();
          push_load(a);
          wait_idle();
        end
      end
    end
    report_test("amo_word", err_before);

    err_before = err_count;
    for (int i = 0; i < N_CONC; i++) begin
      push_load(rand_addr());
      r = $random(seed);
      if (r[0]) begin
        push_store(rand_addr(), rand_data(), r[15:8]);
      end else begin
        a    = rand_addr();
        a[2] = r[1];
        push_amo(rand_op(), r[2], a, rand_data());
      end
    end
    wait_idle();
    // Whole tested range read back against the model
    for (int w = 0; w < N_DUMP; w++) begin
      push_load({8'h00, w[4:0], 3'b000});
    end
    wait_idle();
    report_test("concurrent", err_before);

    assert_fails = dut.u_load_adapter.u_dmem_assert.fail_count
                 + dut.u_store_adapter.u_dmem_assert.fail_count
                 + dut.u_arbiter.u_dmem_assert.fail_count;
    $display("Summary: %0d tests failed, %0d checks, %0d errors, %0d assertion failures",
             tests_failed, check_count, err_count, assert_fails);
    if (err_count == 0 && tests_failed == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/dc_pkg.sv
rtl/core_port_adapter.sv
rtl/port_arbiter.sv
rtl/amo_data_mem.sv
rtl/dmem_subsys_top.sv
verif/dmem_assert.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_top \
  -f flist.f \
  -o tb_sim

./obj_dir/tb_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
fi

echo "Simulation result: FAIL, see sim.log"
exit 1
